// File: hdl/ex_consts.svh
// Execute stage constants
`ifndef EX_CONSTS_SVH
`define EX_CONSTS_SVH

// Primary opcodes
`define OP_SPECIAL  6'h00
`define OP_ADDI     6'h08
`define OP_ADDIU    6'h09
`define OP_SLTI     6'h0a
`define OP_SLTIU    6'h0b
`define OP_ANDI     6'h0c
`define OP_ORI      6'h0d
`define OP_XORI     6'h0e
`define OP_LUI      6'h0f
`define OP_LB       6'h20
`define OP_LH       6'h21
`define OP_LW       6'h23
`define OP_LBU      6'h24
`define OP_LHU      6'h25
`define OP_SB       6'h28
`define OP_SH       6'h29
`define OP_SW       6'h2b

// SPECIAL funct field
`define FN_SLL      6'h00
`define FN_SRL      6'h02
`define FN_SRA      6'h03
`define FN_SLLV     6'h04
`define FN_SRLV     6'h06
`define FN_SRAV     6'h07
`define FN_MFHI     6'h10
`define FN_MFLO     6'h12
`define FN_MULT     6'h18
`define FN_MULTU    6'h19
`define FN_DIV      6'h1a
`define FN_DIVU     6'h1b
`define FN_ADD      6'h20
`define FN_ADDU     6'h21
`define FN_SUB      6'h22
`define FN_SUBU     6'h23
`define FN_AND      6'h24
`define FN_OR       6'h25
`define FN_XOR      6'h26
`define FN_NOR      6'h27
`define FN_SLT      6'h2a
`define FN_SLTU     6'h2b

// ALU operations
`define ALU_ZERO    4'd0
`define ALU_ADD     4'd1
`define ALU_SUB     4'd2
`define ALU_AND     4'd3
`define ALU_OR      4'd4
`define ALU_XOR     4'd5
`define ALU_NOR     4'd6
`define ALU_SLT     4'd7
`define ALU_SLTU    4'd8
`define ALU_SLL     4'd9
`define ALU_SRL     4'd10
`define ALU_SRA     4'd11
`define ALU_LUI     4'd12

// Busy length of the multiply/divide unit
`define MULT_CYCLES 5
`define DIV_CYCLES  10

`endif

// File: hdl/exPkg.sv
// Execute stage types
`default_nettype none

package exPkg;

    // Data and instruction words
    typedef logic [31:0] word_t;

    // Register number where 0 is the zero register
    typedef logic [4:0] regAddr_t;

    typedef logic [3:0] aluOp_t;

    // Instruction fields
    typedef logic [5:0] opcode_t;
    typedef logic [5:0] funct_t;
    typedef logic [4:0] shamt_t;
    typedef logic [15:0] imm16_t;

    // Multiply/divide sequencer
    typedef enum logic [1:0] {
        MD_IDLE,
        MD_MULT,
        MD_DIV
    } mdState_t;

endpackage

`default_nettype wire

// File: hdl/instrDecode.sv
// Instruction decoder
`default_nettype none
`include "ex_consts.svh"

module instrDecode (
    input wire exPkg::word_t instr,
    output exPkg::aluOp_t aluOp,
    output logic useImm,
    output logic signExt,
    output logic shiftByShamt,
    output logic aluWrites,
    output logic memAccess,
    output logic mdStart,
    output logic mdIsDiv,
    output logic mdSigned,
    output logic readHi,
    output logic readLo,
    output logic mdUses
);

    exPkg::opcode_t opcode;
    exPkg::funct_t funct;
    logic isSpecial;

    assign opcode = instr[31:26];
    assign funct = instr[5:0];
    assign isSpecial = (opcode == `OP_SPECIAL);

    always_comb begin
        aluOp = `ALU_ZERO;
        useImm = 1'b0;
        signExt = 1'b0;
        memAccess = 1'b0;
        if (isSpecial) begin
            case (funct)
                `FN_SLL, `FN_SLLV: aluOp = `ALU_SLL;
                `FN_SRL, `FN_SRLV: aluOp = `ALU_SRL;
                `FN_SRA, `FN_SRAV: aluOp = `ALU_SRA;
                `FN_ADD, `FN_ADDU: aluOp = `ALU_ADD;
                `FN_SUB, `FN_SUBU: aluOp = `ALU_SUB;
                `FN_AND: aluOp = `ALU_AND;
                `FN_OR: aluOp = `ALU_OR;
                `FN_XOR: aluOp = `ALU_XOR;
                `FN_NOR: aluOp = `ALU_NOR;
                `FN_SLT: aluOp = `ALU_SLT;
                `FN_SLTU: aluOp = `ALU_SLTU;
                default: aluOp = `ALU_ZERO;
            endcase
        end else begin
            useImm = 1'b1;
            case (opcode)
                `OP_ADDI, `OP_ADDIU: begin
                    aluOp = `ALU_ADD;
                    signExt = 1'b1;
                end
                `OP_SLTI: begin
                    aluOp = `ALU_SLT;
                    signExt = 1'b1;
                end
                `OP_SLTIU: begin
                    aluOp = `ALU_SLTU;
                    signExt = 1'b1;
                end
                // Logical immediates are zero extended
                `OP_ANDI: aluOp = `ALU_AND;
                `OP_ORI: aluOp = `ALU_OR;
                `OP_XORI: aluOp = `ALU_XOR;
                `OP_LUI: aluOp = `ALU_LUI;
                `OP_LB, `OP_LH, `OP_LW, `OP_LBU, `OP_LHU, `OP_SB, `OP_SH, `OP_SW: begin
                    aluOp = `ALU_ADD;
                    signExt = 1'b1;
                    memAccess = 1'b1;
                end
                default: useImm = 1'b0;
            endcase
        end
    end

    // Loads and stores never write the ALU result to a register
    assign aluWrites = (aluOp != `ALU_ZERO) && !memAccess;
    assign shiftByShamt = isSpecial && (funct inside {`FN_SLL, `FN_SRL, `FN_SRA});

    assign mdStart = isSpecial && (funct inside {`FN_MULT, `FN_MULTU, `FN_DIV, `FN_DIVU});
    assign mdIsDiv = isSpecial && (funct inside {`FN_DIV, `FN_DIVU});
    assign mdSigned = isSpecial && (funct inside {`FN_MULT, `FN_DIV});
    assign readHi = isSpecial && (funct == `FN_MFHI);
    assign readLo = isSpecial && (funct == `FN_MFLO);
    assign mdUses = mdStart || readHi || readLo;

endmodule

`default_nettype wire

// File: hdl/alu.sv
// Integer ALU
`default_nettype none
`include "ex_consts.svh"

module alu (
    input wire exPkg::word_t a,
    input wire exPkg::word_t b,
    input wire exPkg::aluOp_t op,
    output exPkg::word_t result
);

    // Shift amount comes from a and the shifted value from b
    logic [4:0] shiftAmt;

    assign shiftAmt = a[4:0];

    always_comb begin
        case (op)
            `ALU_ADD: result = a + b;
            `ALU_SUB: result = a - b;
            `ALU_AND: result = a & b;
            `ALU_OR: result = a | b;
            `ALU_XOR: result = a ^ b;
            `ALU_NOR: result = ~(a | b);
            `ALU_SLT: result = {31'b0, $signed(a) < $signed(b)};
            `ALU_SLTU: result = {31'b0, a < b};
            `ALU_SLL: result = b << shiftAmt;
            `ALU_SRL: result = b >> shiftAmt;
            `ALU_SRA: result = $signed(b) >>> shiftAmt;
            // Immediate into the upper half
            `ALU_LUI: result = {b[15:0], 16'b0};
            default: result = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/mulDivSeq.sv
// Multiply/divide sequencer
`default_nettype none
`include "ex_consts.svh"

module mulDivSeq (
    input wire clk,
    input wire reset,
    input wire start,
    input wire isDiv,
    input wire isSigned,
    input wire hold,
    input wire exPkg::word_t opA,
    input wire exPkg::word_t opB,
    output exPkg::word_t hi,
    output exPkg::word_t lo,
    output logic running
);

    localparam int CNT_W = $clog2(`DIV_CYCLES + 1);

    exPkg::mdState_t state;
    logic [CNT_W-1:0] count;
    logic launch;

    // Captured operands
    exPkg::word_t aReg;
    exPkg::word_t bReg;
    logic signedReg;

    // One extra bit so signed and unsigned share the arithmetic
    logic signed [32:0] extA;
    logic signed [32:0] extB;
    logic signed [65:0] product;
    logic signed [32:0] quotient;
    logic signed [32:0] remainder;
    logic divByZero;

    assign launch = (state == exPkg::MD_IDLE) && start && !hold;
    assign running = (state != exPkg::MD_IDLE);

    assign extA = {signedReg & aReg[31], aReg};
    assign extB = {signedReg & bReg[31], bReg};
    assign product = extA * extB;
    assign quotient = extA / extB;
    assign remainder = extA % extB;
    assign divByZero = (bReg == '0);

    always_ff @(posedge clk) begin
        if (launch) begin
            aReg <= opA;
            bReg <= opB;
            signedReg <= isSigned;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= exPkg::MD_IDLE;
            count <= '0;
            hi <= '0;
            lo <= '0;
        end else if (launch) begin
            state <= isDiv ? exPkg::MD_DIV : exPkg::MD_MULT;
            count <= isDiv ? CNT_W'(`DIV_CYCLES) : CNT_W'(`MULT_CYCLES);
        end else if (running) begin
            if (count == CNT_W'(1)) begin
                // Results land as the counter hits zero
                state <= exPkg::MD_IDLE;
                count <= '0;
                if (state == exPkg::MD_DIV) begin
                    hi <= divByZero ? aReg : remainder[31:0];
                    lo <= divByZero ? '1 : quotient[31:0];
                end else begin
                    hi <= product[63:32];
                    lo <= product[31:0];
                end
            end else begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/executeStage.sv
// Execute stage top level
`default_nettype none

module executeStage (
    input wire clk,
    input wire reset,
    input wire stall,
    input wire clear,
    input wire exPkg::word_t instr,
    input wire exPkg::word_t pc,
    input wire exPkg::word_t dataRs,
    input wire exPkg::word_t dataRt,
    input wire exPkg::regAddr_t addrRs,
    input wire exPkg::regAddr_t addrRt,
    input wire exPkg::regAddr_t regWriteAddr,
    input wire exPkg::word_t regWriteDataIn,
    input wire exPkg::regAddr_t fwdAddrMem,
    input wire exPkg::regAddr_t fwdAddrWb,
    input wire exPkg::word_t fwdDataMem,
    input wire exPkg::word_t fwdDataWb,
    output logic busy,
    output exPkg::word_t instrMem,
    output exPkg::word_t pcMem,
    output exPkg::word_t aluOutMem,
    output exPkg::word_t memWriteDataMem,
    output exPkg::word_t regWriteDataMem,
    output exPkg::regAddr_t regWriteAddrMem,
    output exPkg::regAddr_t addrRtMem
);

    exPkg::aluOp_t aluOp;
    logic useImm;
    logic signExt;
    logic shiftByShamt;
    logic aluWrites;
    logic memAccess;
    logic mdStart;
    logic mdIsDiv;
    logic mdSigned;
    logic readHi;
    logic readLo;
    logic mdUses;
    logic mdRunning;

    exPkg::shamt_t shamt;
    exPkg::imm16_t imm16;
    exPkg::word_t extImm;
    exPkg::word_t rsVal;
    exPkg::word_t rtVal;
    exPkg::word_t aluA;
    exPkg::word_t aluB;
    exPkg::word_t aluResult;
    exPkg::word_t hi;
    exPkg::word_t lo;
    exPkg::word_t writeData;

    // Memory stage wins over write-back and register 0 is never forwarded
    function automatic exPkg::word_t forwardSel(exPkg::regAddr_t addr, exPkg::word_t regVal);
        if (fwdAddrMem == addr && fwdAddrMem != '0)
            return fwdDataMem;
        else if (fwdAddrWb == addr && fwdAddrWb != '0)
            return fwdDataWb;
        return regVal;
    endfunction

    always_comb begin
        rsVal = forwardSel(addrRs, dataRs);
        rtVal = forwardSel(addrRt, dataRt);
    end

    assign shamt = instr[10:6];
    assign imm16 = instr[15:0];
    assign extImm = signExt ? {{16{imm16[15]}}, imm16} : {16'b0, imm16};

    assign aluA = shiftByShamt ? {27'b0, shamt} : rsVal;
    assign aluB = useImm ? extImm : rtVal;

    instrDecode decode (
        .instr(instr),
        .aluOp(aluOp),
        .useImm(useImm),
        .signExt(signExt),
        .shiftByShamt(shiftByShamt),
        .aluWrites(aluWrites),
        .memAccess(memAccess),
        .mdStart(mdStart),
        .mdIsDiv(mdIsDiv),
        .mdSigned(mdSigned),
        .readHi(readHi),
        .readLo(readLo),
        .mdUses(mdUses)
    );

    alu aluUnit (
        .a(aluA),
        .b(aluB),
        .op(aluOp),
        .result(aluResult)
    );

    // A killed or held instruction must not start the unit
    mulDivSeq mulDiv (
        .clk(clk),
        .reset(reset),
        .start(mdStart),
        .isDiv(mdIsDiv),
        .isSigned(mdSigned),
        .hold(stall || clear),
        .opA(rsVal),
        .opB(rtVal),
        .hi(hi),
        .lo(lo),
        .running(mdRunning)
    );

    assign busy = mdRunning && mdUses;

    always_comb begin
        if (aluWrites)
            writeData = aluResult;
        else if (readHi)
            writeData = hi;
        else if (readLo)
            writeData = lo;
        else
            writeData = regWriteDataIn;
    end

    // EX/MEM register
    always_ff @(posedge clk) begin
        if (reset || clear) begin
            instrMem <= '0;
            pcMem <= '0;
            aluOutMem <= '0;
            memWriteDataMem <= '0;
            regWriteDataMem <= '0;
            regWriteAddrMem <= '0;
            addrRtMem <= '0;
        end else if (!stall) begin
            if (busy) begin
                instrMem <= '0;
                pcMem <= '0;
                aluOutMem <= '0;
                memWriteDataMem <= '0;
                regWriteDataMem <= '0;
                regWriteAddrMem <= '0;
                addrRtMem <= '0;
            end else begin
                instrMem <= instr;
                pcMem <= pc;
                aluOutMem <= aluResult;
                memWriteDataMem <= memAccess ? rtVal : '0;
                regWriteDataMem <= writeData;
                regWriteAddrMem <= regWriteAddr;
                addrRtMem <= addrRt;
            end
        end
    end

endmodule

`default_nettype wire

// File: tb/execute_properties.sv
// Execute stage assertions
`default_nettype none
`include "ex_consts.svh"

module executeProperties (
    input wire clk,
    input wire reset,
    input wire stall,
    input wire clear,
    input wire busy,
    input wire exPkg::word_t instrMem,
    input wire exPkg::word_t pcMem,
    input wire exPkg::word_t aluOutMem,
    input wire exPkg::word_t memWriteDataMem,
    input wire exPkg::word_t regWriteDataMem,
    input wire exPkg::regAddr_t regWriteAddrMem,
    input wire exPkg::regAddr_t addrRtMem
);

    int assertFails = 0;
    int busyStreak;

    // Consecutive cycles with busy high
    always_ff @(posedge clk) begin
        if (reset)
            busyStreak <= 0;
        else if (busy)
            busyStreak <= busyStreak + 1;
        else
            busyStreak <= 0;
    end

    resetToBubble: assert property (@(posedge clk)
        reset |=> instrMem == '0 && regWriteAddrMem == '0 && aluOutMem == '0 && !busy)
    else begin
        assertFails++;
        $error("Reset did not leave a bubble with busy low");
    end

    bubbleNoWrite: assert property (@(posedge clk) disable iff (reset)
        instrMem == '0 |-> regWriteAddrMem == '0)
    else begin
        assertFails++;
        $error("Bubble carries a nonzero write address");
    end

    holdOnStall: assert property (@(posedge clk) disable iff (reset)
        stall && !clear |=> $stable(instrMem) && $stable(pcMem) && $stable(aluOutMem)
            && $stable(memWriteDataMem) && $stable(regWriteDataMem)
            && $stable(regWriteAddrMem) && $stable(addrRtMem))
    else begin
        assertFails++;
        $error("EX/MEM outputs changed during a stall");
    end

    busyBounded: assert property (@(posedge clk) disable iff (reset)
        busyStreak <= `DIV_CYCLES)
    else begin
        assertFails++;
        $error("busy stayed high longer than the divide latency");
    end

endmodule

`default_nettype wire

// File: tb/executeChecker.sv
// Execute stage reference checker
`default_nettype none
`include "ex_consts.svh"

module executeChecker (
    input wire clk,
    input wire reset,
    input wire stall,
    input wire clear,
    input wire exPkg::word_t instr,
    input wire exPkg::word_t pc,
    input wire exPkg::word_t dataRs,
    input wire exPkg::word_t dataRt,
    input wire exPkg::regAddr_t addrRs,
    input wire exPkg::regAddr_t addrRt,
    input wire exPkg::regAddr_t regWriteAddr,
    input wire exPkg::word_t regWriteDataIn,
    input wire exPkg::regAddr_t fwdAddrMem,
    input wire exPkg::regAddr_t fwdAddrWb,
    input wire exPkg::word_t fwdDataMem,
    input wire exPkg::word_t fwdDataWb,
    input wire busy,
    input wire exPkg::word_t instrMem,
    input wire exPkg::word_t pcMem,
    input wire exPkg::word_t aluOutMem,
    input wire exPkg::word_t memWriteDataMem,
    input wire exPkg::word_t regWriteDataMem,
    input wire exPkg::regAddr_t regWriteAddrMem,
    input wire exPkg::regAddr_t addrRtMem,
    output int errorCount
);

    // Expected EX/MEM contents
    logic [31:0] expInstr;
    logic [31:0] expPc;
    logic [31:0] expAluOut;
    logic [31:0] expMemData;
    logic [31:0] expWriteData;
    logic [4:0] expWriteAddr;
    logic [4:0] expAddrRt;
    logic armed;

    // Multiply/divide model
    logic [31:0] refHi;
    logic [31:0] refLo;
    logic [31:0] mdA;
    logic [31:0] mdB;
    logic mdRunning;
    logic mdIsDiv;
    logic mdSigned;
    int mdCount;

    initial begin
        errorCount = 0;
        armed = 1'b0;
    end

    function automatic logic [31:0] forwarded(input logic [4:0] addr, input logic [31:0] regVal);
        if (addr != 0 && fwdAddrMem == addr)
            return fwdDataMem;
        if (addr != 0 && fwdAddrWb == addr)
            return fwdDataWb;
        return regVal;
    endfunction

    function automatic logic special(input logic [31:0] ins);
        return ins[31:26] == `OP_SPECIAL;
    endfunction

    function automatic logic startsMd(input logic [31:0] ins);
        return special(ins) && ins[5:0] inside {`FN_MULT, `FN_MULTU, `FN_DIV, `FN_DIVU};
    endfunction

    function automatic logic usesMd(input logic [31:0] ins);
        return startsMd(ins) || (special(ins) && ins[5:0] inside {`FN_MFHI, `FN_MFLO});
    endfunction

    function automatic logic isMem(input logic [31:0] ins);
        return ins[31:26] inside {`OP_LB, `OP_LH, `OP_LW, `OP_LBU, `OP_LHU,
                                  `OP_SB, `OP_SH, `OP_SW};
    endfunction

    function automatic logic writesAlu(input logic [31:0] ins);
        if (special(ins))
            return !usesMd(ins);
        return ins[31:26] inside {`OP_ADDI, `OP_ADDIU, `OP_SLTI, `OP_SLTIU,
                                  `OP_ANDI, `OP_ORI, `OP_XORI, `OP_LUI};
    endfunction

    // Result by instruction straight from opcode and funct
    function automatic logic [31:0] expectAlu(input logic [31:0] ins,
                                              input logic [31:0] rs, input logic [31:0] rt);
        logic [31:0] sext;
        logic [31:0] zext;
        sext = {{16{ins[15]}}, ins[15:0]};
        zext = {16'b0, ins[15:0]};
        if (special(ins)) begin
            case (ins[5:0])
                `FN_SLL: return rt << ins[10:6];
                `FN_SRL: return rt >> ins[10:6];
                `FN_SRA: return $signed(rt) >>> ins[10:6];
                `FN_SLLV: return rt << rs[4:0];
                `FN_SRLV: return rt >> rs[4:0];
                `FN_SRAV: return $signed(rt) >>> rs[4:0];
                `FN_ADD, `FN_ADDU: return rs + rt;
                `FN_SUB, `FN_SUBU: return rs - rt;
                `FN_AND: return rs & rt;
                `FN_OR: return rs | rt;
                `FN_XOR: return rs ^ rt;
                `FN_NOR: return ~(rs | rt);
                `FN_SLT: return ($signed(rs) < $signed(rt)) ? 32'd1 : 32'd0;
                `FN_SLTU: return (rs < rt) ? 32'd1 : 32'd0;
                default: return '0;
            endcase
        end
        if (isMem(ins))
            return rs + sext;
        case (ins[31:26])
            `OP_ADDI, `OP_ADDIU: return rs + sext;
            `OP_SLTI: return ($signed(rs) < $signed(sext)) ? 32'd1 : 32'd0;
            `OP_SLTIU: return (rs < sext) ? 32'd1 : 32'd0;
            `OP_ANDI: return rs & zext;
            `OP_ORI: return rs | zext;
            `OP_XORI: return rs ^ zext;
            `OP_LUI: return {ins[15:0], 16'b0};
            default: return '0;
        endcase
    endfunction

    task automatic loadBubble();
        expInstr = '0;
        expPc = '0;
        expAluOut = '0;
        expMemData = '0;
        expWriteData = '0;
        expWriteAddr = '0;
        expAddrRt = '0;
    endtask

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errorCount++;
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    always @(posedge clk) begin : model
        logic [31:0] rs;
        logic [31:0] rt;
        logic busyNow;
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        logic [63:0] product;
        rs = forwarded(addrRs, dataRs);
        rt = forwarded(addrRt, dataRt);
        busyNow = mdRunning && usesMd(instr);
        if (reset) begin
            loadBubble();
            refHi = '0;
            refLo = '0;
            mdRunning = 1'b0;
            mdCount = 0;
            armed = 1'b1;
        end else begin
            if (clear || (!stall && busyNow)) begin
                loadBubble();
            end else if (!stall) begin
                expInstr = instr;
                expPc = pc;
                expAluOut = expectAlu(instr, rs, rt);
                expMemData = isMem(instr) ? rt : '0;
                if (writesAlu(instr))
                    expWriteData = expAluOut;
                else if (special(instr) && instr[5:0] == `FN_MFHI)
                    expWriteData = refHi;
                else if (special(instr) && instr[5:0] == `FN_MFLO)
                    expWriteData = refLo;
                else
                    expWriteData = regWriteDataIn;
                expWriteAddr = regWriteAddr;
                expAddrRt = addrRt;
            end
            // Stall holds off a new start but not the count
            if (!mdRunning && startsMd(instr) && !stall && !clear) begin
                mdA = rs;
                mdB = rt;
                mdIsDiv = instr[5:0] inside {`FN_DIV, `FN_DIVU};
                mdSigned = instr[5:0] inside {`FN_MULT, `FN_DIV};
                mdCount = mdIsDiv ? `DIV_CYCLES : `MULT_CYCLES;
                mdRunning = 1'b1;
            end else if (mdRunning) begin
                mdCount--;
                if (mdCount == 0) begin
                    mdRunning = 1'b0;
                    sa = mdSigned ? {{32{mdA[31]}}, mdA} : {32'b0, mdA};
                    sb = mdSigned ? {{32{mdB[31]}}, mdB} : {32'b0, mdB};
                    if (!mdIsDiv) begin
                        product = sa * sb;
                        refHi = product[63:32];
                        refLo = product[31:0];
                    end else if (mdB == '0) begin
                        refHi = mdA;
                        refLo = '1;
                    end else begin
                        refHi = 32'(sa % sb);
                        refLo = 32'(sa / sb);
                    end
                end
            end
        end
    end

    // Outputs settle well before the falling edge
    always @(negedge clk) begin
        if (armed) begin
            compare("busy", 32'(busy), 32'(mdRunning && usesMd(instr)));
            compare("instrMem", instrMem, expInstr);
            compare("pcMem", pcMem, expPc);
            compare("aluOutMem", aluOutMem, expAluOut);
            compare("memWriteDataMem", memWriteDataMem, expMemData);
            compare("regWriteDataMem", regWriteDataMem, expWriteData);
            compare("regWriteAddrMem", 32'(regWriteAddrMem), 32'(expWriteAddr));
            compare("addrRtMem", 32'(addrRtMem), 32'(expAddrRt));
        end
    end

endmodule

`default_nettype wire

// File: tb/executeTb.sv
// Execute stage testbench
`default_nettype none
`include "ex_consts.svh"

module executeTb;

    localparam int CLK_PERIOD = 100;
    localparam int DRIVE_DELAY = 10;
    localparam int NUM_INSTR = 2000;
    localparam int WATCHDOG_TIME = CLK_PERIOD * (NUM_INSTR * (`DIV_CYCLES + 2) + 10);

    // Supported R-type functions and I-type opcodes
    localparam logic [5:0] rFuncts [22] = '{
        `FN_SLL, `FN_SRL, `FN_SRA, `FN_SLLV, `FN_SRLV, `FN_SRAV, `FN_ADD, `FN_ADDU,
        `FN_SUB, `FN_SUBU, `FN_AND, `FN_OR, `FN_XOR, `FN_NOR, `FN_SLT, `FN_SLTU,
        `FN_MFHI, `FN_MFLO, `FN_MULT, `FN_MULTU, `FN_DIV, `FN_DIVU
    };
    localparam logic [5:0] iOps [16] = '{
        `OP_ADDI, `OP_ADDIU, `OP_SLTI, `OP_SLTIU, `OP_ANDI, `OP_ORI, `OP_XORI, `OP_LUI,
        `OP_LB, `OP_LH, `OP_LW, `OP_LBU, `OP_LHU, `OP_SB, `OP_SH, `OP_SW
    };

    logic clk;
    logic reset;
    logic stall;
    logic clear;
    exPkg::word_t instr;
    exPkg::word_t pc;
    exPkg::word_t dataRs;
    exPkg::word_t dataRt;
    exPkg::regAddr_t addrRs;
    exPkg::regAddr_t addrRt;
    exPkg::regAddr_t regWriteAddr;
    exPkg::word_t regWriteDataIn;
    exPkg::regAddr_t fwdAddrMem;
    exPkg::regAddr_t fwdAddrWb;
    exPkg::word_t fwdDataMem;
    exPkg::word_t fwdDataWb;
    logic busy;
    exPkg::word_t instrMem;
    exPkg::word_t pcMem;
    exPkg::word_t aluOutMem;
    exPkg::word_t memWriteDataMem;
    exPkg::word_t regWriteDataMem;
    exPkg::regAddr_t regWriteAddrMem;
    exPkg::regAddr_t addrRtMem;
    int mismatches;
    logic [31:0] lfsr;

    executeStage DUT (.*);

    executeChecker scoreboard (.*, .errorCount(mismatches));

    bind executeStage executeProperties props (
        .clk(clk),
        .reset(reset),
        .stall(stall),
        .clear(clear),
        .busy(busy),
        .instrMem(instrMem),
        .pcMem(pcMem),
        .aluOutMem(aluOutMem),
        .memWriteDataMem(memWriteDataMem),
        .regWriteDataMem(regWriteDataMem),
        .regWriteAddrMem(regWriteAddrMem),
        .addrRtMem(addrRtMem)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // 32-bit Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
    function automatic logic [31:0] takeBits(input int n);
        logic [31:0] value;
        logic feedback;
        value = '0;
        for (int i = 0; i < n; i++) begin
            feedback = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], feedback};
            value = {value[30:0], feedback};
        end
        return value;
    endfunction

    // Small register range so forwarding hits often
    task automatic issueInstr();
        logic [5:0] fn;
        logic [5:0] op;
        logic [4:0] rd;
        addrRs = 5'(takeBits(2));
        addrRt = 5'(takeBits(2));
        rd = 5'(takeBits(2));
        dataRs = takeBits(32);
        dataRt = (takeBits(2) == 0) ? '0 : takeBits(32);
        regWriteDataIn = takeBits(32);
        pc = takeBits(30) << 2;
        if (takeBits(1) == 1) begin
            fn = rFuncts[takeBits(5) % 22];
            instr = {`OP_SPECIAL, addrRs, addrRt, rd, 5'(takeBits(5)), fn};
            regWriteAddr = (fn inside {`FN_MULT, `FN_MULTU, `FN_DIV, `FN_DIVU}) ? '0 : rd;
        end else begin
            op = iOps[takeBits(4)];
            instr = {op, addrRs, addrRt, 16'(takeBits(16))};
            regWriteAddr = (op inside {`OP_SB, `OP_SH, `OP_SW}) ? '0 : addrRt;
        end
    endtask

    // Later-stage inputs change every cycle
    task automatic driveControls();
        fwdAddrMem = 5'(takeBits(2));
        fwdAddrWb = 5'(takeBits(2));
        fwdDataMem = (takeBits(3) == 0) ? '0 : takeBits(32);
        fwdDataWb = takeBits(32);
        stall = (takeBits(3) == 0);
        clear = (takeBits(4) == 0);
    endtask

    initial begin
        int issued;
        logic consumed;
        logic done;
        lfsr = 32'd85870;
        reset = 1'b1;
        stall = 1'b0;
        clear = 1'b0;
        instr = '0;
        pc = '0;
        dataRs = '0;
        dataRt = '0;
        addrRs = '0;
        addrRt = '0;
        regWriteAddr = '0;
        regWriteDataIn = '0;
        fwdAddrMem = '0;
        fwdAddrWb = '0;
        fwdDataMem = '0;
        fwdDataWb = '0;
        repeat (2) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;
        issueInstr();
        driveControls();
        issued = 1;
        done = 1'b0;
        while (!done) begin
            // Killed by clear or taken with no stall and no busy
            @(negedge clk);
            consumed = clear || (!stall && !busy);
            @(posedge clk);
            #DRIVE_DELAY;
            if (consumed && issued == NUM_INSTR) begin
                done = 1'b1;
            end else begin
                if (consumed) begin
                    issueInstr();
                    issued++;
                end
                driveControls();
            end
        end
        // Let the last falling-edge compare finish first
        @(negedge clk);
        #DRIVE_DELAY;
        $display("Errors: %0d mismatches, %0d assertion failures",
                 mismatches, DUT.props.assertFails);
        if (mismatches == 0 && DUT.props.assertFails == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin
        #WATCHDOG_TIME;
        $display("Timeout: the instruction stream did not finish in time");
        $display("Errors: %0d mismatches, %0d assertion failures",
                 mismatches, DUT.props.assertFails);
        $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
+incdir+hdl
hdl/exPkg.sv
hdl/instrDecode.sv
hdl/alu.sv
hdl/mulDivSeq.sv
hdl/executeStage.sv
tb/execute_properties.sv
tb/executeChecker.sv
tb/executeTb.sv

// File: run.sh
#!/bin/sh
# Build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module executeTb \
    -f flist.f -o executeSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/executeSim +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q -F "** FAIL **" "$LOG"; then
    echo "Simulation reported failure"
    exit 1
fi
exit 0
